// File: lynx_video.f
logic/lynx_video_pkg.sv
logic/raster_if.sv
logic/video_csr.sv
logic/raster_timer.sv
logic/frame_store.sv
logic/flicker_blender.sv
logic/lynx_video.sv
tb/lynx_video_asserts.sv
tb/tb_lynx_video.sv

// File: tb/tb_lynx_video.sv
// Testbench with clock, reset, AXI and pixel tasks, directed video tests and watchdog
`timescale 1ns/1ps

module tb_lynx_video;
	import lynx_video_pkg::*;

	localparam int     pix_div     = 1;
	localparam int     h_total     = 445;
	localparam int     v_total     = 270;
	localparam int     clk_period  = 4;
	localparam int     frame_clks  = pix_div * h_total * v_total;
	localparam longint watchdog_ns = longint'(10) * frame_clks * clk_period;
	localparam int     axi_wait    = 32;   // Clocks allowed for a handshake

	logic              clk_sys = 1'b0;
	logic              arst_n;
	logic [csr_aw-1:0] awaddr;
	logic              awvalid;
	logic              awready;
	logic [31:0]       wdata;
	logic [3:0]        wstrb;
	logic              wvalid;
	logic              wready;
	logic [1:0]        bresp;
	logic              bvalid;
	logic              bready;
	logic [csr_aw-1:0] araddr;
	logic              arvalid;
	logic              arready;
	logic [31:0]       rdata;
	logic [1:0]        rresp;
	logic              rvalid;
	logic              rready;
	logic              pixel_we;
	pix_addr_t         pixel_addr;
	rgb12_t            pixel_data;
	logic [7:0]        red;
	logic [7:0]        green;
	logic [7:0]        blue;
	logic              hs;
	logic              vs;
	logic              hblank;
	logic              vblank;
	logic              ce_pix;

	rgb12_t      frames [4][frame_words];   // A, B, C and the unbuffered frame
	int          value_errors = 0;
	int          other_errors = 0;
	int unsigned assert_fails;

	always #(clk_period / 2) clk_sys = ~clk_sys;

	lynx_video #(
		.pix_div (pix_div),
		.h_total (h_total),
		.v_total (v_total)
	) DUT (.*);

	////////////////////////////////////////////////////////////////////////////
	// Reporting and expected values
	task automatic report_value(input string name, input int expected, input int actual);
		value_errors++;
		$display("error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
	endtask

	// One 8-bit channel from up to three 4-bit samples
	function automatic logic [7:0] expected_chan(input blend_mode_e mode, input int a,
	                                             input int b, input int c);
		int sum;
		int wide;
		case (mode)
			blend_two: begin
				sum = a + b;
				return 8'((sum << 3) | (sum >> 2));
			end
			blend_three: begin
				sum  = a + b + c;
				wide = (sum << 2) | (sum >> 4);
				return 8'((wide * 21845) >> 14);
			end
			default: return 8'(a * 17);   // Nibble repeated
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Bus and pixel drivers
	task automatic axi_write(input logic [csr_aw-1:0] addr, input logic [31:0] data,
	                         output logic [1:0] resp);
		int waited;
		@(negedge clk_sys);
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hf;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		waited  = 0;
		while (!bvalid && waited < axi_wait) begin
			@(negedge clk_sys);
			waited++;
		end
		awvalid = 1'b0;
		wvalid  = 1'b0;
		resp    = bresp;
		if (!bvalid) begin
			other_errors++;
			$display("write to offset 0x%0h got no response", addr);
			return;
		end
		@(negedge clk_sys);   // Response left waiting one clock
		bready = 1'b1;
		@(negedge clk_sys);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [csr_aw-1:0] addr, output logic [31:0] data,
	                        output logic [1:0] resp);
		int waited;
		@(negedge clk_sys);
		araddr  = addr;
		arvalid = 1'b1;
		waited  = 0;
		while (!rvalid && waited < axi_wait) begin
			@(negedge clk_sys);
			waited++;
		end
		arvalid = 1'b0;
		data    = rdata;
		resp    = rresp;
		if (!rvalid) begin
			other_errors++;
			$display("read of offset 0x%0h got no data", addr);
			return;
		end
		@(negedge clk_sys);
		rready = 1'b1;
		@(negedge clk_sys);
		rready = 1'b0;
	endtask

	task automatic write_frame(input int f);
		for (int n = 0; n < frame_words; n++) begin
			@(negedge clk_sys);
			pixel_we   = 1'b1;
			pixel_addr = pix_addr_t'(n);
			pixel_data = frames[f][n];
		end
		@(negedge clk_sys);
		pixel_we = 1'b0;
	endtask

	// Returns on the falling edge where the last slot of the frame is shown
	task automatic wait_frame_end();
		int waited;
		waited = 0;
		@(negedge clk_sys);
		while (!DUT.rt.frame_end && waited <= frame_clks) begin
			@(negedge clk_sys);
			waited++;
		end
		if (!DUT.rt.frame_end) begin
			other_errors++;
			$display("no frame end within one frame time");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output checkers
	task automatic check_frame(input blend_mode_e mode, input int fa, input int fb,
	                           input int fc);
		int n;
		int waited;
		logic [7:0] exp_r;
		logic [7:0] exp_g;
		logic [7:0] exp_b;
		n      = 0;
		waited = 0;
		while (n < frame_words && waited < frame_clks) begin
			@(negedge clk_sys);
			waited++;
			if (ce_pix && !hblank && !vblank) begin
				exp_r = expected_chan(mode, frames[fa][n].r, frames[fb][n].r, frames[fc][n].r);
				exp_g = expected_chan(mode, frames[fa][n].g, frames[fb][n].g, frames[fc][n].g);
				exp_b = expected_chan(mode, frames[fa][n].b, frames[fb][n].b, frames[fc][n].b);
				if (red !== exp_r)
					report_value($sformatf("red[%0d]", n), exp_r, red);
				if (green !== exp_g)
					report_value($sformatf("green[%0d]", n), exp_g, green);
				if (blue !== exp_b)
					report_value($sformatf("blue[%0d]", n), exp_b, blue);
				n++;
			end
		end
		if (n != frame_words) begin
			other_errors++;
			$display("frame ended after %0d of %0d active samples", n, frame_words);
		end
	endtask

	task automatic measure_raster(input int clocks, input int hs_offset, input int pulses,
	                              input bit whole_frame);
		int  active_cnt;
		int  vs_cnt;
		int  hs_run;
		int  hs_cnt;
		int  since_hbl;
		bit  hbl_seen;
		bit  hs_prev;
		bit  hbl_prev;
		active_cnt = 0;
		vs_cnt     = 0;
		hs_run     = 0;
		hs_cnt     = 0;
		since_hbl  = 0;
		hbl_seen   = 1'b0;
		hs_prev    = hs;
		hbl_prev   = hblank;
		for (int i = 0; i < clocks; i++) begin
			@(negedge clk_sys);
			if (ce_pix) begin
				if (!hblank && !vblank)
					active_cnt++;
				if (vs)
					vs_cnt++;
				if (hbl_prev && !hblank) begin   // Slot 0 of a line
					since_hbl = 0;
					hbl_seen  = 1'b1;
				end else begin
					since_hbl++;
				end
				if (hs && !hs_prev) begin
					hs_cnt++;
					hs_run = 1;
					if (hbl_seen && since_hbl != hs_offset)
						report_value("hs start slot", hs_offset, since_hbl);
				end else if (hs) begin
					hs_run++;
				end
				if (!hs && hs_prev && hs_run != hs_width)
					report_value("hs length", hs_width, hs_run);
				hs_prev  = hs;
				hbl_prev = hblank;
			end
		end
		if (hs_cnt != pulses)
			report_value("hs pulse count", pulses, hs_cnt);
		if (whole_frame) begin
			if (active_cnt != frame_words)
				report_value("active samples", frame_words, active_cnt);
			if (vs_cnt != 3 * h_total)
				report_value("vs slots", 3 * h_total, vs_cnt);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	task automatic reset_outputs();
		if (ce_pix !== 1'b0) report_value("ce_pix", 0, ce_pix);
		if (hs !== 1'b0) report_value("hs", 0, hs);
		if (vs !== 1'b0) report_value("vs", 0, vs);
		if (hblank !== 1'b1) report_value("hblank", 1, hblank);
		if (vblank !== 1'b1) report_value("vblank", 1, vblank);
		if (bvalid !== 1'b0) report_value("bvalid", 0, bvalid);
		if (rvalid !== 1'b0) report_value("rvalid", 0, rvalid);
		if (awready !== 1'b0) report_value("awready", 0, awready);
		if (wready !== 1'b0) report_value("wready", 0, wready);
		if (arready !== 1'b0) report_value("arready", 0, arready);
	endtask

	task automatic csr_readback();
		logic [1:0]  resp;
		logic [31:0] data;
		axi_write(csr_ctrl_addr, 32'h3, resp);
		if (resp !== axi_okay) report_value("bresp", axi_okay, resp);
		axi_read(csr_ctrl_addr, data, resp);
		if (data !== 32'h3) report_value("rdata CTRL", 32'h3, data);
		if (resp !== axi_okay) report_value("rresp", axi_okay, resp);
		axi_write(csr_shift_addr, 32'h5, resp);
		if (resp !== axi_okay) report_value("bresp", axi_okay, resp);
		axi_read(csr_shift_addr, data, resp);
		if (data !== 32'h5) report_value("rdata SHIFT", 32'h5, data);
		if (resp !== axi_okay) report_value("rresp", axi_okay, resp);

		// Unmapped offset
		axi_write(4'h8, 32'h7, resp);
		if (resp !== axi_slverr) report_value("bresp", axi_slverr, resp);
		axi_read(4'h8, data, resp);
		if (data !== 32'h0) report_value("rdata 0x8", 0, data);
		if (resp !== axi_slverr) report_value("rresp", axi_slverr, resp);
		axi_read(csr_ctrl_addr, data, resp);
		if (data !== 32'h3) report_value("rdata CTRL", 32'h3, data);

		axi_write(csr_ctrl_addr, 32'h0, resp);
		axi_write(csr_shift_addr, 32'h0, resp);
	endtask

	task automatic raster_timing();
		wait_frame_end();
		measure_raster(frame_clks, hs_start, v_total, 1'b1);
	endtask

	task automatic unbuffered_output();
		write_frame(3);
		wait_frame_end();
		check_frame(blend_off, 3, 3, 3);
	endtask

	task automatic two_frame_blend();
		logic [1:0] resp;
		axi_write(csr_ctrl_addr, 32'h3, resp);   // buffer_en with blend_two
		write_frame(0);
		wait_frame_end();
		wait_frame_end();
		write_frame(1);
		wait_frame_end();
		check_frame(blend_two, 1, 0, 0);         // Spans up to the second frame end
	endtask

	task automatic three_frame_blend();
		logic [1:0] resp;
		axi_write(csr_ctrl_addr, 32'h5, resp);
		write_frame(2);
		wait_frame_end();
		check_frame(blend_three, 0, 1, 2);
	endtask

	task automatic sync_shift();
		logic [1:0] resp;
		axi_write(csr_shift_addr, 32'hc, resp);  // -4
		wait_frame_end();
		measure_raster(4 * h_total * pix_div, hs_start - 4, 4, 1'b0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	initial begin
		logic [31:0] rnd;
		rnd        = $urandom(32'hd86e3c3f);
		arst_n     = 1'b0;
		awaddr     = '0;
		awvalid    = 1'b0;
		wdata      = '0;
		wstrb      = '0;
		wvalid     = 1'b0;
		bready     = 1'b0;
		araddr     = '0;
		arvalid    = 1'b0;
		rready     = 1'b0;
		pixel_we   = 1'b0;
		pixel_addr = '0;
		pixel_data = '0;
		for (int f = 0; f < 4; f++) begin
			for (int n = 0; n < frame_words; n++) begin
				rnd          = $urandom();
				frames[f][n] = rnd[11:0];
			end
		end

		repeat (8) @(negedge clk_sys);
		reset_outputs();
		arst_n = 1'b1;

		csr_readback();
		raster_timing();
		unbuffered_output();
		two_frame_blend();
		three_frame_blend();
		sync_shift();

		repeat (4) @(negedge clk_sys);
		assert_fails = DUT.u_asserts.fail_count;
		$display("errors: %0d value, %0d handshake or timing, %0d assertion",
		         value_errors, other_errors, assert_fails);
		if (value_errors == 0 && other_errors == 0 && assert_fails == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// Ten frames of run time
	initial begin
		#(watchdog_ns);
		$display("watchdog expired before the tests completed");
		$display("Test FAILED");
		$finish;
	end

endmodule

// File: tb/lynx_video_asserts.sv
// Bound assertions on AXI response hold, bus back-pressure and hsync pulse length
`timescale 1ns/1ps

module lynx_video_asserts (
	input logic clk_sys,
	input logic arst_n,
	input logic awready,
	input logic wready,
	input logic arready,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic hs,
	input logic ce_pix
);
	import lynx_video_pkg::*;

	int unsigned fail_count = 0;   // Read by the testbench at the end
	int          hs_slots;

	// Pixel slots seen in the current hs pulse
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			hs_slots <= 0;
		else if (!hs)
			hs_slots <= 0;
		else if (ce_pix)
			hs_slots <= hs_slots + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Bus responses
	bvalid_hold: assert property (@(posedge clk_sys) disable iff (!arst_n)
		bvalid && !bready |=> bvalid)
		else begin
			$error("bvalid dropped before bready");
			fail_count++;
		end

	rvalid_hold: assert property (@(posedge clk_sys) disable iff (!arst_n)
		rvalid && !rready |=> rvalid)
		else begin
			$error("rvalid dropped before rready");
			fail_count++;
		end

	// No new transfer while a response waits
	ready_blocked: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(bvalid || rvalid) |-> (!awready && !wready && !arready))
		else begin
			$error("ready raised while a response was pending");
			fail_count++;
		end

	////////////////////////////////////////////////////////////////////////////
	// Sync
	hs_length: assert property (@(posedge clk_sys) disable iff (!arst_n)
		hs_slots <= hs_width)
		else begin
			$error("hs longer than %0d slots", hs_width);
			fail_count++;
		end

endmodule

bind lynx_video lynx_video_asserts u_asserts (
	.clk_sys (clk_sys),
	.arst_n  (arst_n),
	.awready (awready),
	.wready  (wready),
	.arready (arready),
	.bvalid  (bvalid),
	.bready  (bready),
	.rvalid  (rvalid),
	.rready  (rready),
	.hs      (hs),
	.ce_pix  (ce_pix)
);

// File: logic/lynx_video.sv
// Video back end top with settings bus, beam timer, triple frame store and blender
`timescale 1ns/1ps

module lynx_video #(
	parameter int pix_div = 9,     // Clocks per pixel
	parameter int h_total = 445,   // Pixel slots per line
	parameter int v_total = 270    // Lines per frame
) (
	input  logic                              clk_sys,
	input  logic                              arst_n,
	// AXI4-Lite settings port
	input  logic [lynx_video_pkg::csr_aw-1:0] awaddr,
	input  logic                              awvalid,
	output logic                              awready,
	input  logic [31:0]                       wdata,
	input  logic [3:0]                        wstrb,
	input  logic                              wvalid,
	output logic                              wready,
	output logic [1:0]                        bresp,
	output logic                              bvalid,
	input  logic                              bready,
	input  logic [lynx_video_pkg::csr_aw-1:0] araddr,
	input  logic                              arvalid,
	output logic                              arready,
	output logic [31:0]                       rdata,
	output logic [1:0]                        rresp,
	output logic                              rvalid,
	input  logic                              rready,
	// Pixel writes from the emulated system
	input  logic                              pixel_we,
	input  lynx_video_pkg::pix_addr_t         pixel_addr,
	input  lynx_video_pkg::rgb12_t            pixel_data,
	// Video out
	output logic [7:0]                        red,
	output logic [7:0]                        green,
	output logic [7:0]                        blue,
	output logic                              hs,
	output logic                              vs,
	output logic                              hblank,
	output logic                              vblank,
	output logic                              ce_pix
);
	import lynx_video_pkg::*;

	video_cfg_t   cfg;
	rgb12_t       word_now;
	rgb12_t       word_last;
	rgb12_t [2:0] word_all;

	raster_if rt ();

	video_csr u_csr (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.cfg     (cfg)
	);

	raster_timer #(
		.pix_div (pix_div),
		.h_total (h_total),
		.v_total (v_total)
	) u_timer (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.cfg     (cfg),
		.rt      (rt.timer),
		.hs      (hs),
		.vs      (vs)
	);

	frame_store u_store (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.cfg        (cfg),
		.rt         (rt.store),
		.pixel_we   (pixel_we),
		.pixel_addr (pixel_addr),
		.pixel_data (pixel_data),
		.word_now   (word_now),
		.word_last  (word_last),
		.word_all   (word_all)
	);

	flicker_blender u_blend (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.cfg       (cfg),
		.rt        (rt.blend),
		.word_now  (word_now),
		.word_last (word_last),
		.word_all  (word_all),
		.red       (red),
		.green     (green),
		.blue      (blue),
		.hblank_o  (hblank),
		.vblank_o  (vblank),
		.ce_pix_o  (ce_pix)
	);

endmodule

// File: logic/flicker_blender.sv
// Flicker blend of current and older frames into 8-bit RGB with aligned blanking
`timescale 1ns/1ps

module flicker_blender (
	input  logic                         clk_sys,
	input  logic                         arst_n,
	input  lynx_video_pkg::video_cfg_t   cfg,
	raster_if.blend                      rt,
	input  lynx_video_pkg::rgb12_t       word_now,
	input  lynx_video_pkg::rgb12_t       word_last,
	input  lynx_video_pkg::rgb12_t [2:0] word_all,
	output logic [7:0]                   red,
	output logic [7:0]                   green,
	output logic [7:0]                   blue,
	output logic                         hblank_o,
	output logic                         vblank_o,
	output logic                         ce_pix_o
);
	import lynx_video_pkg::*;

	logic ce_d;
	logic hbl_d;
	logic vbl_d;

	// One color channel
	function automatic logic [7:0] blend_chan(
		input blend_mode_e mode,
		input logic [3:0]  cur,
		input logic [3:0]  prev,
		input logic [3:0]  c0,
		input logic [3:0]  c1,
		input logic [3:0]  c2
	);
		logic [4:0]  sum2;
		logic [5:0]  sum3;
		logic [7:0]  ext3;
		logic [23:0] prod;
		sum2 = cur + prev;
		sum3 = c0 + c1 + c2;
		ext3 = {sum3, sum3[5:4]};
		prod = ext3 * 24'd21845;   // Roughly a divide by three after the shift
		case (mode)
			blend_two:   return {sum2, sum2[4:2]};
			blend_three: return prod[21:14];
			default:     return {cur, cur};
		endcase
	endfunction

	// Store data arrives one clock after the slot starts
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ce_d     <= 1'b0;
			hbl_d    <= 1'b1;
			vbl_d    <= 1'b1;
			ce_pix_o <= 1'b0;
			hblank_o <= 1'b1;
			vblank_o <= 1'b1;
		end else begin
			ce_d     <= rt.ce_pix;
			hbl_d    <= rt.hblank;
			vbl_d    <= rt.vblank;
			ce_pix_o <= ce_d;
			if (ce_d) begin
				hblank_o <= hbl_d;
				vblank_o <= vbl_d;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ce_d) begin
			red   <= blend_chan(cfg.blend, word_now.r, word_last.r,
			                    word_all[0].r, word_all[1].r, word_all[2].r);
			green <= blend_chan(cfg.blend, word_now.g, word_last.g,
			                    word_all[0].g, word_all[1].g, word_all[2].g);
			blue  <= blend_chan(cfg.blend, word_now.b, word_last.b,
			                    word_all[0].b, word_all[1].b, word_all[2].b);
		end
	end

endmodule

// File: logic/frame_store.sv
// Triple frame buffer with write rotation and current and last display selection
`timescale 1ns/1ps

module frame_store (
	input  logic                             clk_sys,
	input  logic                             arst_n,
	input  lynx_video_pkg::video_cfg_t       cfg,
	raster_if.store                          rt,
	input  logic                             pixel_we,
	input  lynx_video_pkg::pix_addr_t        pixel_addr,
	input  lynx_video_pkg::rgb12_t           pixel_data,
	output lynx_video_pkg::rgb12_t           word_now,
	output lynx_video_pkg::rgb12_t           word_last,
	output lynx_video_pkg::rgb12_t [2:0]     word_all
);
	import lynx_video_pkg::*;

	rgb12_t     vram [3][frame_words];
	logic       rot_on;
	logic       frame_done;
	logic [1:0] wr_idx;
	logic [1:0] next_idx;   // Last completed buffer
	logic [1:0] rd_idx;
	logic [1:0] last_idx;

	assign rot_on     = cfg.buffer_en || (cfg.blend != blend_off);
	assign frame_done = pixel_we && (pixel_addr == pix_addr_t'(frame_words - 1));

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr_idx   <= '0;
			next_idx <= '0;
			rd_idx   <= '0;
			last_idx <= '0;
		end else begin
			if (!rot_on) begin
				wr_idx   <= '0;
				next_idx <= '0;
			end else if (frame_done) begin
				next_idx <= wr_idx;
				wr_idx   <= (wr_idx == 2'd2) ? 2'd0 : wr_idx + 1'b1;
			end

			if (rt.frame_end) begin
				last_idx <= rd_idx;
				rd_idx   <= next_idx;
			end
		end
	end

	// All three buffers read each clock for the blender
	always_ff @(posedge clk_sys) begin
		for (int i = 0; i < 3; i++) begin
			if (pixel_we && (wr_idx == i))
				vram[i][pixel_addr] <= pixel_data;
			word_all[i] <= vram[i][rt.rd_addr];
		end
	end

	assign word_now  = word_all[rd_idx];
	assign word_last = word_all[last_idx];

endmodule

// File: logic/raster_timer.sv
// Pixel enable divider, beam counters, blanking, sync and frame read address walk
`timescale 1ns/1ps

module raster_timer #(
	parameter int pix_div = 9,
	parameter int h_total = 445,
	parameter int v_total = 270
) (
	input  logic                       clk_sys,
	input  logic                       arst_n,
	input  lynx_video_pkg::video_cfg_t cfg,
	raster_if.timer                    rt,
	output logic                       hs,
	output logic                       vs
);
	import lynx_video_pkg::*;

	localparam int dw = (pix_div > 1) ? $clog2(pix_div) : 1;
	localparam int xw = $clog2(h_total);
	localparam int yw = $clog2(v_total);

	logic [dw-1:0]     div;
	logic              tick;
	logic [xw-1:0]     x;
	logic [yw-1:0]     y;
	logic [xw-1:0]     x_next;
	logic [yw-1:0]     y_next;
	logic              x_last;
	logic              y_last;
	logic              n_hblank;
	logic              n_vblank;
	logic              active;
	logic signed [3:0] shift_q;
	logic [xw-1:0]     hs_on;
	logic [xw-1:0]     hs_off;
	logic              hs_slot;
	logic              vs_slot;
	logic              hs_d;
	logic              vs_d;

	assign tick = (div == dw'(pix_div - 1));

	// x and y describe the slot currently shown
	assign x_last = (x == xw'(h_total - 1));
	assign y_last = (y == yw'(v_total - 1));
	assign x_next = x_last ? '0 : x + 1'b1;
	assign y_next = x_last ? (y_last ? '0 : y + 1'b1) : y;

	assign n_hblank = (x_next >= frame_w);
	assign n_vblank = (y_next < v_active_start) || (y_next >= v_active_start + frame_h);
	assign active   = !rt.hblank && !rt.vblank;

	// Sync window moves with the latched shift
	assign hs_on  = xw'(hs_start + int'(shift_q));
	assign hs_off = xw'(hs_start + hs_width + int'(shift_q));

	assign rt.frame_end = rt.ce_pix && x_last && y_last;

	////////////////////////////////////////////////////////////////////////////
	// Beam
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			div        <= '0;
			rt.ce_pix  <= 1'b0;
			x          <= xw'(h_total - 1);   // First tick enters slot 0 of line 0
			y          <= yw'(v_total - 1);
			rt.hblank  <= 1'b1;
			rt.vblank  <= 1'b1;
			rt.rd_addr <= '0;
			shift_q    <= '0;
			hs_slot    <= 1'b0;
			vs_slot    <= 1'b0;
		end else begin
			div       <= tick ? '0 : div + 1'b1;
			rt.ce_pix <= tick;

			if (rt.frame_end)
				shift_q <= cfg.hshift;

			if (tick) begin
				x         <= x_next;
				y         <= y_next;
				rt.hblank <= n_hblank;
				rt.vblank <= n_vblank;

				// Raster order walk, restarted in vertical blank
				if (n_vblank)
					rt.rd_addr <= '0;
				else if (active)
					rt.rd_addr <= (rt.rd_addr == pix_addr_t'(frame_words - 1)) ? '0
					                                                          : rt.rd_addr + 1'b1;

				if (x_next == hs_on) begin
					hs_slot <= 1'b1;
					if (y_next == yw'(vs_first))
						vs_slot <= 1'b1;
					if (y_next == yw'(vs_last + 1))
						vs_slot <= 1'b0;
				end else if (x_next == hs_off) begin
					hs_slot <= 1'b0;
				end
			end
		end
	end

	// Two clocks to match the store read and blender register
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			hs_d <= 1'b0;
			vs_d <= 1'b0;
			hs   <= 1'b0;
			vs   <= 1'b0;
		end else begin
			hs_d <= hs_slot;
			vs_d <= vs_slot;
			hs   <= hs_d;
			vs   <= vs_d;
		end
	end

endmodule

// File: logic/video_csr.sv
// AXI4-Lite slave holding the CTRL and SHIFT video settings
`timescale 1ns/1ps

module video_csr (
	input  logic                              clk_sys,
	input  logic                              arst_n,
	// Write address and data
	input  logic [lynx_video_pkg::csr_aw-1:0] awaddr,
	input  logic                              awvalid,
	output logic                              awready,
	input  logic [31:0]                       wdata,
	input  logic [3:0]                        wstrb,
	input  logic                              wvalid,
	output logic                              wready,
	// Write response
	output logic [1:0]                        bresp,
	output logic                              bvalid,
	input  logic                              bready,
	// Read address and data
	input  logic [lynx_video_pkg::csr_aw-1:0] araddr,
	input  logic                              arvalid,
	output logic                              arready,
	output logic [31:0]                       rdata,
	output logic [1:0]                        rresp,
	output logic                              rvalid,
	input  logic                              rready,
	output lynx_video_pkg::video_cfg_t        cfg
);
	import lynx_video_pkg::*;

	csr_state_e state;
	logic       wr_go;
	logic       rd_go;
	logic       wr_known;

	// Address and data are taken in the same cycle, writes win over reads
	assign wr_go    = (state == idle) && awvalid && wvalid;
	assign rd_go    = (state == idle) && arvalid && !wr_go;
	assign wr_known = (awaddr == csr_ctrl_addr) || (awaddr == csr_shift_addr);

	assign awready = wr_go;
	assign wready  = wr_go;
	assign arready = rd_go;
	assign bvalid  = (state == write_resp);
	assign rvalid  = (state == read_data);

	////////////////////////////////////////////////////////////////////////////
	// Handshake FSM and settings
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= idle;
			cfg   <= '0;
		end else begin
			case (state)
				idle: begin
					if (wr_go)
						state <= write_resp;
					else if (rd_go)
						state <= read_data;
				end
				write_resp: if (bready) state <= idle;
				read_data:  if (rready) state <= idle;
				default:    state <= idle;
			endcase

			// All fields sit in byte 0
			if (wr_go && wstrb[0]) begin
				if (awaddr == csr_ctrl_addr) begin
					cfg.buffer_en <= wdata[0];
					// Code 3 also selects three frames
					cfg.blend     <= (wdata[2:1] == 2'b11) ? blend_three
					                                       : blend_mode_e'(wdata[2:1]);
				end else if (awaddr == csr_shift_addr) begin
					cfg.hshift <= wdata[3:0];
				end
			end
		end
	end

	// Response payload
	always_ff @(posedge clk_sys) begin
		if (wr_go)
			bresp <= wr_known ? axi_okay : axi_slverr;

		if (rd_go) begin
			case (araddr)
				csr_ctrl_addr: begin
					rdata <= {29'd0, cfg.blend, cfg.buffer_en};
					rresp <= axi_okay;
				end
				csr_shift_addr: begin
					rdata <= {28'd0, cfg.hshift};
					rresp <= axi_okay;
				end
				default: begin
					rdata <= 32'd0;       // Unmapped offset
					rresp <= axi_slverr;
				end
			endcase
		end
	end

endmodule

// File: logic/raster_if.sv
// Raster timing bundle from the beam timer to the frame store and the blender
`timescale 1ns/1ps

interface raster_if;
	import lynx_video_pkg::*;

	logic      ce_pix;      // One pixel slot per pulse
	logic      hblank;
	logic      vblank;
	logic      frame_end;   // Single clock in the last slot of the last line
	pix_addr_t rd_addr;     // Frame word for the slot just entered

	// Beam timer owns every signal
	modport timer (
		output ce_pix,
		output hblank,
		output vblank,
		output frame_end,
		output rd_addr
	);

	// Frame store follows the read address and rotates at frame end
	modport store (
		input frame_end,
		input rd_addr
	);

	// Blender lines up blanking with the fetched words
	modport blend (
		input ce_pix,
		input hblank,
		input vblank
	);

endinterface

// File: logic/lynx_video_pkg.sv
// Frame geometry, color and settings types, sync constants and CSR map for the video back end
package lynx_video_pkg;

	// Active picture of the handheld LCD
	localparam int frame_w     = 160;
	localparam int frame_h     = 102;
	localparam int frame_words = frame_w * frame_h;   // 16320

	typedef logic [13:0] pix_addr_t;

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb12_t;

	typedef enum logic [1:0] {
		blend_off   = 2'd0,
		blend_two   = 2'd1,   // Current and previous frame
		blend_three = 2'd2    // All three buffers
	} blend_mode_e;

	typedef struct packed {
		logic              buffer_en;
		blend_mode_e       blend;
		logic signed [3:0] hshift;
	} video_cfg_t;

	//////////////////////////////////////////////////////////////////////////
	// Raster constants
	localparam int v_active_start = 120;
	localparam int hs_start       = 350;
	localparam int hs_width       = 32;
	localparam int vs_first       = 1;
	localparam int vs_last        = 3;

	//////////////////////////////////////////////////////////////////////////
	// Register map and bus responses
	localparam int                csr_aw         = 4;
	localparam logic [csr_aw-1:0] csr_ctrl_addr  = 4'h0;
	localparam logic [csr_aw-1:0] csr_shift_addr = 4'h4;

	localparam logic [1:0] axi_okay   = 2'b00;
	localparam logic [1:0] axi_slverr = 2'b10;

	typedef enum logic [1:0] {
		idle,
		write_resp,
		read_data
	} csr_state_e;

endpackage
